/* vga_board_view.f */
+incdir+include
design/board_view_pkg.sv
design/scan_slice.sv
design/widget_overlay.sv
design/digit_overlay.sv
design/sprite_addr_arbiter.sv
design/vga_board_view.sv
bench/board_view_tb.sv

/* Bender.yml */
package:
  name: vga_board_view

sources:
  - files:
      - design/board_view_pkg.sv
      - design/scan_slice.sv
      - design/widget_overlay.sv
      - design/digit_overlay.sv
      - design/sprite_addr_arbiter.sv
      - design/vga_board_view.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/board_view_tb.sv

/* include/board_view_cases.svh */
`ifndef BOARD_VIEW_CASES_SVH
`define BOARD_VIEW_CASES_SVH

// columns: name, x, y, board state, expected address.
// colour rows add the pixel byte, blank and expected {red, green, blue}.
task automatic fill_cases();
	board_state_t idle;
	board_state_t busy;
	idle = make_board(4'hf, 10'h000, 1'b1, 16'h0000);
	busy = make_board(4'h0, 10'h3ff, 1'b0, 16'h9999); // every element active.

	add_case("bg_top_row", 100, 0, idle, background_addr(100, 0));
	add_colour(8'hff, 1'b0, 9'b011_111_111);
	add_case("bg_plain", 300, 200, idle, background_addr(300, 200));
	add_colour(8'hb5, 1'b0, 9'b010_101_101);

	add_case("btn0_pressed", 390, 430, make_board(4'b1110, 10'h000, 1'b1, 16'h0000),
		rule_addr(390, 430, 58, 0));
	add_colour(8'h18, 1'b0, 9'b011_000_000);
	add_case("btn0_released", 390, 430, idle, background_addr(390, 430));
	add_colour(8'hff, 1'b1, 9'b000_000_000);
	add_case("btn3_pressed", 270, 420, make_board(4'b0111, 10'h000, 1'b1, 16'h0000),
		rule_addr(270, 420, 58, 0));

	add_case("sw0_on", 235, 440, make_board(4'hf, 10'h001, 1'b1, 16'h0000),
		rule_addr(235, 440, 56, 0));
	add_colour(8'he7, 1'b0, 9'b000_111_111);
	add_case("sw0_off", 235, 440, idle, background_addr(235, 440));
	add_case("sw9_on", 50, 450, make_board(4'hf, 10'h200, 1'b1, 16'h0000),
		rule_addr(50, 450, 56, 0));

	add_case("led_g7_lit", 268, 400, make_board(4'hf, 10'h000, 1'b0, 16'h0000),
		rule_addr(268, 400, 65, 0));
	add_case("led_g7_dark", 268, 400, idle, background_addr(268, 400));
	add_case("led_r9_lit", 52, 405, make_board(4'hf, 10'h000, 1'b0, 16'h0000),
		rule_addr(52, 405, 65, 0));

	// slot 0 takes the full hex range.
	for (int v = 0; v < 16; v++)
		add_case($sformatf("digit0_value_%0h", v), 120, 360,
			make_board(4'hf, 10'h000, 1'b1, 16'(v)), rule_addr(120, 360, glyph_row(v), 353));

	add_case("digit3_value_9", 50, 360, make_board(4'hf, 10'h000, 1'b1, 16'h9000),
		rule_addr(50, 360, glyph_row(9), 419));
	add_case("digit3_value_c", 50, 360, make_board(4'hf, 10'h000, 1'b1, 16'hc000),
		background_addr(50, 360));

	add_case("prio_widget_all_on", 390, 430, busy, rule_addr(390, 430, 58, 0));
	add_case("prio_led_all_on", 268, 400, busy, rule_addr(268, 400, 65, 0));
	add_case("prio_digit_all_on", 120, 360, busy, rule_addr(120, 360, glyph_row(9), 353));
endtask

`endif

/* bench/board_view_tb.sv */
`timescale 1ns/100ps

module board_view_tb import board_view_pkg::*;
();

	localparam int wait_limit = 200; // cycles per handshake wait.
	localparam int run_limit = 20000;

	typedef struct {
		string name;
		int x;
		int y;
		board_state_t board;
		logic [addr_w-1:0] exp_addr;
		logic use_colour;
		logic [7:0] pixel;
		logic blank;
		logic [8:0] exp_rgb;
	} case_t;

	logic clk_50;
	logic arst_n;
	pixel_req_t req;
	logic req_valid;
	logic req_ready;
	logic [addr_w-1:0] addr;
	logic addr_valid;
	logic addr_ready;
	logic [7:0] pixel_data;
	logic blank;
	logic [2:0] red;
	logic [2:0] green;
	logic [2:0] blue;

	case_t cases[$];
	int sent_idx[$]; // oldest request in flight at the front.
	int pass_count;
	int fail_count;
	string pass_tag;
	logic [31:0] lfsr;
	logic random_ready;

	vga_board_view dut (
		.clk_50(clk_50),
		.arst_n(arst_n),
		.req(req),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.addr(addr),
		.addr_valid(addr_valid),
		.addr_ready(addr_ready),
		.pixel_data(pixel_data),
		.blank(blank),
		.red(red),
		.green(green),
		.blue(blue)
	);

	initial
	begin
		clk_50 = 1'b0;
		forever #4 clk_50 = ~clk_50;
	end

	// one memory row per screen line.
	function automatic logic [addr_w-1:0] rule_addr(int x, int y, int row_off, int col_off);
		int flat;
		flat = (y - 1 + row_off) * 512 + x + col_off;
		return flat[addr_w-1:0];
	endfunction

	function automatic logic [addr_w-1:0] background_addr(int x, int y);
		if (y == 0)
			return addr_w'(x);
		return rule_addr(x, y, 0, 0);
	endfunction

	function automatic int glyph_row(int v);
		if (v <= 12)
			return -206 + 28 * v;
		else if (v == 13)
			return -234;
		else if (v == 14)
			return -262;
		return -290;
	endfunction

	function automatic board_state_t make_board(logic [3:0] buttons_n, logic [9:0] switches,
		logic blink, logic [15:0] digits);
		board_state_t b;
		b.buttons_n = buttons_n;
		b.switches = switches;
		b.blink = blink;
		b.digits = digits; // index 3 is the leftmost slot.
		return b;
	endfunction

	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic add_case(string name, int x, int y, board_state_t board,
		logic [addr_w-1:0] exp_addr);
		case_t c;
		c.name = name;
		c.x = x;
		c.y = y;
		c.board = board;
		c.exp_addr = exp_addr;
		c.use_colour = 1'b0;
		c.pixel = 8'h00;
		c.blank = 1'b0;
		c.exp_rgb = 9'h000;
		cases.push_back(c);
	endtask

	task automatic add_colour(logic [7:0] pixel, logic blank_in, logic [8:0] exp_rgb);
		cases[cases.size() - 1].use_colour = 1'b1;
		cases[cases.size() - 1].pixel = pixel;
		cases[cases.size() - 1].blank = blank_in;
		cases[cases.size() - 1].exp_rgb = exp_rgb;
	endtask

	`include "board_view_cases.svh"

	task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
		if (expected === actual)
		begin
			pass_count++;
			$display("Pass %s", name);
		end
		else
		begin
			fail_count++;
			$display("Fail %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic report_error(string what);
		fail_count++;
		$display("%s", what);
	endtask

	task automatic send_cases();
		int waited;
		for (int i = 0; i < cases.size(); i++)
		begin
			@(posedge clk_50);
			#1;
			req.x = coord_w'(cases[i].x);
			req.y = coord_w'(cases[i].y);
			req.board = cases[i].board;
			req_valid = 1'b1;
			waited = 0;
			@(negedge clk_50);
			while (!req_ready && waited < wait_limit)
			begin
				@(negedge clk_50);
				waited++;
			end
			if (!req_ready)
			begin
				report_error($sformatf("request %s was never accepted", cases[i].name));
				break;
			end
			sent_idx.push_back(i); // taken on the coming edge.
		end
		@(posedge clk_50);
		#1;
		req_valid = 1'b0;
	endtask

	task automatic collect_addrs(int total);
		int got;
		int idle;
		int idx;
		got = 0;
		idle = 0;
		while (got < total && idle < wait_limit)
		begin
			@(negedge clk_50);
			if (addr_valid && addr_ready)
			begin
				if (sent_idx.size() == 0)
					report_error("an address came out with no request in flight");
				else
				begin
					idx = sent_idx.pop_front();
					check_value({pass_tag, "/", cases[idx].name}, cases[idx].exp_addr, addr);
				end
				got++;
				idle = 0;
			end
			else
				idle++;
		end
		if (got < total)
			report_error($sformatf("timed out waiting for addr_valid after %0d addresses", got));
		repeat (4) @(negedge clk_50);
		if (addr_valid)
			report_error("the pipeline still holds an address after the burst");
	endtask

	task automatic check_colours();
		@(posedge clk_50);
		#1;
		for (int i = 0; i < cases.size(); i++)
		begin
			if (cases[i].use_colour)
			begin
				pixel_data = cases[i].pixel;
				blank = cases[i].blank;
				@(posedge clk_50);
				#1;
				check_value({cases[i].name, "/colour"}, cases[i].exp_rgb, {red, green, blue});
			end
		end
		pixel_data = 8'h00;
		blank = 1'b0;
	endtask

	// one lfsr bit per cycle for addr_ready under back-pressure.
	always @(posedge clk_50)
	begin
		#1;
		if (random_ready)
		begin
			lfsr = lfsr_next(lfsr);
			addr_ready = lfsr[0];
		end
		else
			addr_ready = 1'b1;
	end

	initial
	begin
		repeat (run_limit) @(posedge clk_50);
		$display("simulation ran past its cycle limit");
		$display("CHECKS FAILED");
		$finish;
	end

	initial
	begin
		arst_n = 1'b0;
		req = '0;
		req_valid = 1'b0;
		addr_ready = 1'b1;
		pixel_data = 8'h00;
		blank = 1'b0;
		lfsr = 32'h5db2;
		random_ready = 1'b0;
		pass_count = 0;
		fail_count = 0;
		pass_tag = "steady";
		fill_cases();
		repeat (5) @(posedge clk_50);
		#1;
		arst_n = 1'b1;
		check_value("reset_req_ready", 1, req_ready);
		check_value("reset_addr_valid", 0, addr_valid);
		check_value("reset_colour", 0, {red, green, blue});

		fork
			send_cases();
			collect_addrs(cases.size());
		join

		pass_tag = "backpressure";
		random_ready = 1'b1;
		fork
			send_cases();
			collect_addrs(cases.size());
		join
		random_ready = 1'b0;

		check_colours();

		$display("%0d checks passed, %0d checks failed", pass_count, fail_count);
		if (fail_count == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* design/vga_board_view.sv */
`timescale 1ns/100ps

module vga_board_view import board_view_pkg::*;
(
	input logic clk_50,
	input logic arst_n,
	input pixel_req_t req,
	input logic req_valid,
	output logic req_ready,
	output logic [addr_w-1:0] addr,
	output logic addr_valid,
	input logic addr_ready,
	input logic [7:0] pixel_data,
	input logic blank,
	output logic [2:0] red,
	output logic [2:0] green,
	output logic [2:0] blue
);

	pixel_req_t cur;
	logic cur_valid;
	logic cur_ready;
	sprite_hit_t widget_hit;
	sprite_hit_t digit_hit;

	scan_slice u_scan_slice (
		.clk_50(clk_50),
		.arst_n(arst_n),
		.req(req),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.cur(cur),
		.cur_valid(cur_valid),
		.cur_ready(cur_ready)
	);

	// both overlays look at the same held request.
	widget_overlay u_widget_overlay (
		.cur(cur),
		.widget_hit(widget_hit)
	);

	digit_overlay u_digit_overlay (
		.cur(cur),
		.digit_hit(digit_hit)
	);

	sprite_addr_arbiter u_sprite_addr_arbiter (
		.clk_50(clk_50),
		.arst_n(arst_n),
		.cur(cur),
		.cur_valid(cur_valid),
		.cur_ready(cur_ready),
		.widget_hit(widget_hit),
		.digit_hit(digit_hit),
		.addr(addr),
		.addr_valid(addr_valid),
		.addr_ready(addr_ready)
	);

	// byte is gggrrbbb with red at 4:3.
	always_ff @(posedge clk_50 or negedge arst_n)
	begin
		if (!arst_n)
		begin
			red <= 3'd0;
			green <= 3'd0;
			blue <= 3'd0;
		end
		else if (blank)
		begin
			red <= 3'd0;
			green <= 3'd0;
			blue <= 3'd0;
		end
		else
		begin
			red <= {1'b0, pixel_data[4:3]};
			green <= pixel_data[7:5];
			blue <= pixel_data[2:0];
		end
	end

endmodule

/* design/sprite_addr_arbiter.sv */
`timescale 1ns/100ps

module sprite_addr_arbiter import board_view_pkg::*;
(
	input logic clk_50,
	input logic arst_n,
	input pixel_req_t cur,
	input logic cur_valid,
	output logic cur_ready,
	input sprite_hit_t widget_hit,
	input sprite_hit_t digit_hit,
	output logic [addr_w-1:0] addr,
	output logic addr_valid,
	input logic addr_ready
);

	logic [addr_w-1:0] bg_addr;
	logic [addr_w-1:0] next_addr;

	// top row has no row above it to wrap from.
	assign bg_addr = (cur.y == '0) ? addr_w'(cur.x) : sprite_addr(cur.x, cur.y, 0, 0);

	always_comb
	begin
		if (widget_hit.hit)
			next_addr = widget_hit.addr;
		else if (digit_hit.hit)
			next_addr = digit_hit.addr;
		else
			next_addr = bg_addr;
	end

	assign cur_ready = !addr_valid || addr_ready;

	always_ff @(posedge clk_50 or negedge arst_n)
	begin
		if (!arst_n)
			addr_valid <= 1'b0;
		else if (cur_ready)
			addr_valid <= cur_valid;
	end

	always_ff @(posedge clk_50)
	begin
		if (cur_ready && cur_valid)
			addr <= next_addr; // winner of this pixel.
	end

	a_addr_hold: assert property (@(posedge clk_50) disable iff (!arst_n)
		addr_valid && !addr_ready |=> addr_valid && $stable(addr));

endmodule

/* design/digit_overlay.sv */
`timescale 1ns/100ps

module digit_overlay import board_view_pkg::*;
(
	input pixel_req_t cur,
	output sprite_hit_t digit_hit
);

	logic found;
	logic [1:0] slot;
	logic [3:0] value;
	logic in_rows;
	logic legal;

	// slot search, left to right on screen.
	always_comb
	begin
		found = 1'b0;
		slot = 2'd0;
		for (int s = 3; s >= 0; s--)
		begin
			if (!found && cur.x >= digit_x_lo[s] && cur.x <= digit_x_lo[s] + digit_w - 1)
			begin
				found = 1'b1;
				slot = 2'(s);
			end
		end
	end

	assign value = cur.board.digits[slot];
	assign in_rows = in_span(cur.y, digit_y_lo, digit_y_hi);

	// left pair has no hex glyphs.
	assign legal = (slot < 2'd2) || (value <= dec_max);

	assign digit_hit.hit = found && in_rows && legal;
	assign digit_hit.addr = sprite_addr(cur.x, cur.y, glyph_row_off[value],
		digit_col_off[slot]);

endmodule

/* design/widget_overlay.sv */
`timescale 1ns/100ps

module widget_overlay import board_view_pkg::*;
(
	input pixel_req_t cur,
	output sprite_hit_t widget_hit
);

	logic btn_col;
	logic sw_col;
	logic led_col;
	logic btn_on;
	logic sw_on;
	logic led_on;
	int row_off;

	always_comb
	begin
		btn_col = 1'b0;
		sw_col = 1'b0;
		led_col = 1'b0;
		for (int i = 3; i >= 0; i--)
		begin
			if (!cur.board.buttons_n[i] && in_span(cur.x, btn_x_lo[i], btn_x_hi[i]))
				btn_col = 1'b1; // pressed is low.
		end
		for (int i = 0; i < 10; i++)
		begin
			if (cur.board.switches[i] && in_span(cur.x, sw_x_lo[i], sw_x_hi[i]))
				sw_col = 1'b1;
		end
		for (int i = 0; i < 18; i++)
		begin
			if (in_span(cur.x, led_x_lo[i], led_x_hi[i]))
				led_col = 1'b1;
		end
	end

	assign btn_on = btn_col && in_span(cur.y, btn_y_lo, btn_y_hi);
	assign sw_on = sw_col && in_span(cur.y, sw_y_lo, sw_y_hi);
	// every led follows blink, lit while it is low.
	assign led_on = led_col && !cur.board.blink && in_span(cur.y, led_y_lo, led_y_hi);

	always_comb
	begin
		if (btn_on)
			row_off = btn_row_off;
		else if (sw_on)
			row_off = sw_row_off;
		else
			row_off = led_row_off;
	end

	assign widget_hit.hit = btn_on || sw_on || led_on;
	assign widget_hit.addr = sprite_addr(cur.x, cur.y, row_off, 0);

	// a widget sprite only ever lands on the widget rows of the board.
	always_comb
	begin
		a_widget_rows: assert final (!widget_hit.hit
			|| in_span(cur.y, btn_y_lo, btn_y_hi)
			|| in_span(cur.y, sw_y_lo, sw_y_hi)
			|| in_span(cur.y, led_y_lo, led_y_hi));
	end

endmodule

/* design/scan_slice.sv */
`timescale 1ns/100ps

module scan_slice import board_view_pkg::*;
(
	input logic clk_50,
	input logic arst_n,
	input pixel_req_t req,
	input logic req_valid,
	output logic req_ready,
	output pixel_req_t cur,
	output logic cur_valid,
	input logic cur_ready
);

	logic take;

	assign req_ready = !cur_valid || cur_ready; // empty or draining.
	assign take = req_valid && req_ready;

	always_ff @(posedge clk_50 or negedge arst_n)
	begin
		if (!arst_n)
			cur_valid <= 1'b0;
		else if (req_ready)
			cur_valid <= req_valid;
	end

	always_ff @(posedge clk_50)
	begin
		if (take)
			cur <= req;
	end

	// a stalled request must not move under the overlays.
	a_cur_hold: assert property (@(posedge clk_50) disable iff (!arst_n)
		cur_valid && !cur_ready |=> cur_valid && $stable(cur));

endmodule

/* design/board_view_pkg.sv */
package board_view_pkg;

	localparam int coord_w = 10;
	localparam int addr_w = 18;
	localparam int line_words = 512; // one memory row of the atlas.

	// buttons, index is the button number.
	localparam logic [coord_w-1:0] btn_x_lo [4] = '{379, 339, 299, 260};
	localparam logic [coord_w-1:0] btn_x_hi [4] = '{412, 372, 332, 292};
	localparam logic [coord_w-1:0] btn_y_lo = 417;
	localparam logic [coord_w-1:0] btn_y_hi = 449;

	// switches, index is the switch number.
	localparam logic [coord_w-1:0] sw_x_lo [10] =
		'{230, 210, 190, 170, 148, 128, 108, 86, 66, 46};
	localparam logic [coord_w-1:0] sw_x_hi [10] =
		'{244, 224, 204, 184, 162, 142, 122, 100, 80, 60};
	localparam logic [coord_w-1:0] sw_y_lo = 417;
	localparam logic [coord_w-1:0] sw_y_hi = 451;

	// green 7 down to 0, then red 0 to 9.
	localparam logic [coord_w-1:0] led_x_lo [18] =
		'{267, 287, 309, 329, 349, 369, 389, 409,
		  235, 215, 195, 175, 153, 133, 113, 91, 71, 51};
	localparam logic [coord_w-1:0] led_x_hi [18] =
		'{270, 290, 312, 332, 352, 372, 392, 412,
		  238, 218, 198, 178, 156, 136, 116, 94, 74, 54};
	localparam logic [coord_w-1:0] led_y_lo = 399;
	localparam logic [coord_w-1:0] led_y_hi = 406;

	// seven segment slots, slot 3 is the leftmost.
	localparam int digit_w = 14;
	localparam logic [coord_w-1:0] digit_x_lo [3:0] = '{47, 69, 91, 113};
	localparam logic [coord_w-1:0] digit_y_lo = 349;
	localparam logic [coord_w-1:0] digit_y_hi = 374;
	localparam int dec_max = 9; // left pair is decimal only.

	localparam int btn_row_off = 58;
	localparam int sw_row_off = 56;
	localparam int led_row_off = 65;

	// glyphs sit above the board image, hence the negative rows.
	localparam int glyph_row_off [16] =
		'{-206, -178, -150, -122, -94, -66, -38, -10,
		  18, 46, 74, 102, 130, -234, -262, -290};
	localparam int digit_col_off [3:0] = '{419, 397, 375, 353};

	typedef struct packed {
		logic [3:0] buttons_n;
		logic [9:0] switches;
		logic blink;
		logic [3:0][3:0] digits;
	} board_state_t;

	typedef struct packed {
		logic [coord_w-1:0] x;
		logic [coord_w-1:0] y;
		board_state_t board;
	} pixel_req_t;

	typedef struct packed {
		logic hit;
		logic [addr_w-1:0] addr;
	} sprite_hit_t;

	function automatic logic in_span(
		logic [coord_w-1:0] v,
		logic [coord_w-1:0] lo,
		logic [coord_w-1:0] hi
	);
		return (v >= lo) && (v <= hi);
	endfunction

	// wraps modulo the address width.
	function automatic logic [addr_w-1:0] sprite_addr(
		logic [coord_w-1:0] x,
		logic [coord_w-1:0] y,
		int row_off,
		int col_off
	);
		int row;
		row = int'(y) - 1 + row_off;
		return addr_w'(row * line_words + int'(x) + col_off);
	endfunction

endpackage
